//--- files.f
logic/asi_pkg.sv
logic/sha3_index.sv
logic/sha256_sigma.sv
logic/aes_sbox.sv
logic/aes_sub_mix.sv
logic/asi_unit.sv
bench/asi_checker.sv
bench/asi_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --top-module asi_tb -f files.f -o asi_sim \
    && ./obj_dir/asi_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat "$LOG"
grep -q "Finished with errors" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" "$LOG" || { echo "Simulation incomplete"; exit 1; }
echo "Simulation PASSED"

//--- bench/asi_tb.sv
`timescale 1ns/10ps
// Testbench for the crypto instruction unit
// Random requests from a fixed seed, checked against a reference model
module asi_tb;
    import asi_pkg::*;

    localparam int N_SHA2   = 400;  // SHA-256 sigma ops
    localparam int N_SMALL  = 125;  // Five functions by 25 small pairs
    localparam int N_SHA3   = 40;   // Per SHA3 function
    localparam int N_SUB    = 60;   // SubBytes, alternating direction
    localparam int N_MIX    = 50;   // Three ops each
    localparam int N_STALL  = 40;   // Idle gap plus op each
    localparam int N_UNDEF  = 20;
    localparam int N_OPS    = N_SHA2 + N_SMALL + 5 * N_SHA3 + N_SUB + 3 * N_MIX
                            + 2 * N_STALL + N_UNDEF + 4;
    localparam int WATCHDOG_CYC = N_OPS * 6 + 50;

    // FIPS-197 S-box, row 0 first
    localparam logic [2047:0] SBOX_FWD = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam asi_uop_t ALL_OPS [13] = '{
        ASI_AES_ENCS, ASI_AES_DECS, ASI_AES_ENCM, ASI_AES_DECM,
        ASI_SHA256_S0, ASI_SHA256_S1, ASI_SHA256_S2, ASI_SHA256_S3,
        ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX
    };

    logic        g_clk = 1'b0;
    logic        rst;
    logic        valid;
    asi_req_t    req;
    logic        ready;
    word_t       result;
    logic [7:0]  sbox_inv [256];  // Built from the forward table

    asi_unit uut (
        .g_clk  (g_clk),
        .rst    (rst),
        .valid  (valid),
        .req    (req),
        .ready  (ready),
        .result (result)
    );

    bind asi_unit asi_checker u_checker (
        .g_clk  (g_clk),
        .rst    (rst),
        .valid  (valid),
        .req    (req),
        .ready  (ready),
        .result (result)
    );

    always #5 g_clk = ~g_clk;  // 100 MHz

    // ----------------------------------------
    // Reference model

    function automatic logic [7:0] sbox_fwd(input logic [7:0] b);
        return SBOX_FWD[2047 - 8 * int'(b) -: 8];
    endfunction

    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = '0;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p ^= t;
            t = (t << 1) ^ (t[7] ? 8'h1b : 8'h00);  // Reduce by the AES polynomial
        end
        return p;
    endfunction

    function automatic word_t rotr(input word_t v, input int n);
        return (v >> n) | (v << (32 - n));
    endfunction

    function automatic word_t mix_model(input word_t w, input logic inv);
        logic [7:0] a [4];
        logic [7:0] k [4];
        word_t      r;
        for (int i = 0; i < 4; i++) begin
            a[i] = w[8*i +: 8];  // Byte 0 is row 0
        end
        if (inv) k = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
        else k = '{8'h02, 8'h03, 8'h01, 8'h01};
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = gmul(k[0], a[i]) ^ gmul(k[1], a[(i+1)%4])
                        ^ gmul(k[2], a[(i+2)%4]) ^ gmul(k[3], a[(i+3)%4]);
        end
        return r;
    endfunction

    function automatic word_t sha3_model(input asi_req_t r);
        int unsigned x;
        int unsigned y;
        int unsigned base;
        x = r.rs1 % 5;
        y = r.rs2 % 5;
        case (r.uop)
            ASI_SHA3_XY: base = x + 5 * y;
            ASI_SHA3_X1: base = (x + 1) % 5 + 5 * y;
            ASI_SHA3_X2: base = (x + 2) % 5 + 5 * y;
            ASI_SHA3_X4: base = (x + 4) % 5 + 5 * y;
            default:     base = y + 5 * ((2 * x + 3 * y) % 5);  // YX
        endcase
        return word_t'(base) << r.shamt;
    endfunction

    function automatic word_t model_result(input asi_req_t r);
        word_t w;
        w = r.rs1;
        case (r.uop)
            ASI_AES_ENCS:  return {sbox_fwd(w[31:24]), sbox_fwd(w[23:16]),
                                   sbox_fwd(w[15:8]), sbox_fwd(w[7:0])};
            ASI_AES_DECS:  return {sbox_inv[w[31:24]], sbox_inv[w[23:16]],
                                   sbox_inv[w[15:8]], sbox_inv[w[7:0]]};
            ASI_AES_ENCM:  return mix_model(w, 1'b0);
            ASI_AES_DECM:  return mix_model(w, 1'b1);
            ASI_SHA256_S0: return rotr(w, 7) ^ rotr(w, 18) ^ (w >> 3);
            ASI_SHA256_S1: return rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
            ASI_SHA256_S2: return rotr(w, 2) ^ rotr(w, 13) ^ rotr(w, 22);
            ASI_SHA256_S3: return rotr(w, 6) ^ rotr(w, 11) ^ rotr(w, 25);
            ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX:
                return sha3_model(r);
            default:       return '0;  // Undefined op
        endcase
    endfunction

    function automatic logic is_defined(input asi_uop_t u);
        for (int i = 0; i < 13; i++) begin
            if (ALL_OPS[i] == u) return 1'b1;
        end
        return 1'b0;
    endfunction

    // ----------------------------------------
    // Stimulus helpers

    function automatic word_t rand_val();
        return ($urandom_range(0, 3) == 0) ? word_t'($urandom_range(0, 4)) : $urandom;
    endfunction

    function automatic asi_req_t make_req(input asi_uop_t u);
        asi_req_t r;
        r.uop   = u;
        r.rs1   = rand_val();
        r.rs2   = rand_val();
        r.shamt = shamt_t'($urandom_range(0, 3));
        return r;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("ERROR: time %0t signal %s expected %h got %h", $time, name, exp, got);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Wait for ready on a request already on the bus, then check it
    task automatic wait_result(input asi_req_t r, input word_t exp);
        int cyc;
        int exp_lat;
        exp_lat = (r.uop inside {ASI_AES_ENCS, ASI_AES_DECS}) ? 4 : 1;
        cyc = 0;
        do begin
            @(negedge g_clk);
            cyc++;
        end while (!ready);
        check_value("result", exp, result);
        check_value("ready latency", word_t'(exp_lat), word_t'(cyc));
    endtask

    // Present one request and hold it until ready
    task automatic run_op(input asi_req_t r, input word_t exp);
        @(posedge g_clk);
        valid <= 1'b1;
        req   <= r;
        wait_result(r, exp);
    endtask

    task automatic idle_gap(input int n);
        @(posedge g_clk);
        valid <= 1'b0;
        req   <= make_req(asi_uop_t'($urandom_range(0, 31)));  // Noise on idle bus
        repeat (n) begin
            @(negedge g_clk);
            check_value("result", '0, result);
            check_value("ready", '0, word_t'(ready));
        end
    endtask

    // ----------------------------------------
    // Watchdog

    initial begin
        repeat (WATCHDOG_CYC) @(posedge g_clk);
        $display("Watchdog expired after %0d cycles, the run timed out", WATCHDOG_CYC);
        $display("Finished with errors");
        $fatal(1, "Timeout");
    end

    // ----------------------------------------
    // Main sequence

    initial begin
        asi_req_t r;
        asi_uop_t u;
        word_t    w;
        word_t    m;
        void'($urandom(32'hb98e));
        rst   <= 1'b1;
        valid <= 1'b0;
        req   <= '0;
        for (int i = 0; i < 256; i++) begin
            sbox_inv[sbox_fwd(8'(i))] = 8'(i);
        end
        repeat (2) @(posedge g_clk);
        rst <= 1'b0;

        for (int i = 0; i < N_SHA2; i++) begin  // SHA-256 sigmas
            r = make_req(asi_uop_t'({ASI_CLS_SHA2, 3'(i % 4)}));
            run_op(r, model_result(r));
        end

        for (int i = 0; i < N_SMALL; i++) begin  // Every small x, y pair per function
            r = make_req(asi_uop_t'({ASI_CLS_SHA3, 3'(i / 25)}));
            r.rs1 = word_t'(i % 5);
            r.rs2 = word_t'((i / 5) % 5);
            run_op(r, model_result(r));
        end
        for (int f = 0; f < 5; f++) begin
            for (int i = 0; i < N_SHA3; i++) begin
                r = make_req(asi_uop_t'({ASI_CLS_SHA3, 3'(f)}));
                run_op(r, model_result(r));
            end
        end

        for (int i = 0; i < N_SUB; i++) begin  // Back to back SubBytes
            r = make_req((i % 2 == 0) ? ASI_AES_ENCS : ASI_AES_DECS);
            run_op(r, model_result(r));
        end

        for (int i = 0; i < N_MIX; i++) begin
            w = $urandom;
            r = make_req(ASI_AES_ENCM);
            r.rs1 = w;
            m = model_result(r);
            run_op(r, m);
            r = make_req(ASI_AES_DECM);
            r.rs1 = m;
            run_op(r, w);  // Round trip restores the column
            r = make_req(ASI_AES_DECM);
            run_op(r, model_result(r));
        end

        for (int i = 0; i < N_STALL; i++) begin
            idle_gap($urandom_range(1, 3));
            r = make_req(ALL_OPS[$urandom_range(0, 12)]);
            run_op(r, model_result(r));
        end

        for (int i = 0; i < N_UNDEF; i++) begin
            do begin
                u = asi_uop_t'($urandom_range(0, 31));
            end while (is_defined(u));
            r = make_req(u);
            run_op(r, '0);
        end

        // Reset in the middle of a SubBytes, valid held high throughout
        @(posedge g_clk);
        valid <= 1'b1;
        req   <= make_req(ASI_AES_ENCS);
        repeat (2) @(posedge g_clk);
        rst <= 1'b1;  // Two bytes already done
        @(posedge g_clk);
        rst <= 1'b0;
        r = make_req(ASI_AES_ENCS);
        req <= r;     // Next op starts as reset releases
        wait_result(r, model_result(r));
        r = make_req(ASI_AES_DECS);
        run_op(r, model_result(r));

        idle_gap(2);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- bench/asi_checker.sv
`timescale 1ns/10ps
// Handshake and latency assertions for the crypto instruction unit
module asi_checker (
    input logic              g_clk,
    input logic              rst,
    input logic              valid,
    input asi_pkg::asi_req_t req,
    input logic              ready,
    input asi_pkg::word_t    result
);
    import asi_pkg::*;

    logic valid_q;    // Valid one cycle back
    logic ready_q;    // Ready one cycle back
    logic is_sub;     // SubBytes request on the bus
    logic sub_start;  // First cycle of a SubBytes op

    always_ff @(posedge g_clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            valid_q <= valid;
            ready_q <= ready;
        end
    end

    assign is_sub    = valid && (req.uop inside {ASI_AES_ENCS, ASI_AES_DECS});
    assign sub_start = is_sub && (!valid_q || ready_q);  // New op or after handshake

    // ----------------------------------------
    // Idle bus

    a_ready_idle: assert property (@(posedge g_clk) disable iff (rst) !valid |-> !ready)
        else $error("ready high while valid is low");

    a_result_idle: assert property (@(posedge g_clk) disable iff (rst)
        !valid |-> result == '0)
        else $error("result not zero while valid is low");

    // ----------------------------------------
    // Latency

    a_fast_ops: assert property (@(posedge g_clk) disable iff (rst)
        (valid && !is_sub) |-> ready)
        else $error("single-cycle op not ready with valid");

    a_sub_early: assert property (@(posedge g_clk) disable iff (rst) sub_start |-> !ready)
        else $error("SubBytes ready in its first cycle");

    a_sub_latency: assert property (@(posedge g_clk) disable iff (rst)
        (is_sub && ready) |-> $past(sub_start, 3) && !$past(ready, 1) && !$past(ready, 2))
        else $error("SubBytes ready not exactly 3 cycles after start");

endmodule

//--- logic/asi_unit.sv
`timescale 1ns/10ps
// Algorithm-specific instruction unit of the execute stage
// Decodes one crypto micro-op, runs it and returns a 32-bit result
module asi_unit (
    input  logic              g_clk,  // Core clock
    input  logic              rst,    // Sync reset, active high
    input  logic              valid,  // Request present
    input  asi_pkg::asi_req_t req,    // Micro-op and operands
    output logic              ready,  // Op completes this cycle
    output asi_pkg::word_t    result  // Meaningful only with ready
);
    import asi_pkg::*;

    asi_cls_t cls;
    logic     sel_aes;     // Class selects
    logic     sel_sha2;
    logic     sel_sha3;
    logic     f_encs;      // AES functions
    logic     f_decs;
    logic     f_encm;
    logic     f_decm;
    logic     f_xy;        // SHA3 functions
    logic     f_x1;
    logic     f_x2;
    logic     f_x4;
    logic     f_yx;
    logic     insn_aes;
    logic     insn_sha2;
    logic     insn_sha3;
    logic     insn_undef;  // Completes with zero
    logic     aes_dec;
    logic     aes_mix;
    logic     aes_ready;
    word_t    sha2_rs1;
    word_t    result_aes;
    word_t    result_sha2;
    word_t    result_sha3;

    // ----------------------------------------
    // Decode

    assign cls      = req.uop[4:3];
    assign sel_aes  = valid && (cls == ASI_CLS_AES);
    assign sel_sha2 = valid && (cls == ASI_CLS_SHA2);
    assign sel_sha3 = valid && (cls == ASI_CLS_SHA3);

    assign f_encs = sel_aes && (req.uop == ASI_AES_ENCS);
    assign f_decs = sel_aes && (req.uop == ASI_AES_DECS);
    assign f_encm = sel_aes && (req.uop == ASI_AES_ENCM);
    assign f_decm = sel_aes && (req.uop == ASI_AES_DECM);

    assign f_xy = sel_sha3 && (req.uop == ASI_SHA3_XY);
    assign f_x1 = sel_sha3 && (req.uop == ASI_SHA3_X1);
    assign f_x2 = sel_sha3 && (req.uop == ASI_SHA3_X2);
    assign f_x4 = sel_sha3 && (req.uop == ASI_SHA3_X4);
    assign f_yx = sel_sha3 && (req.uop == ASI_SHA3_YX);

    assign insn_aes   = f_encs | f_decs | f_encm | f_decm;
    assign insn_sha2  = sel_sha2 && (req.uop inside {ASI_SHA256_S0, ASI_SHA256_S1,
                                                     ASI_SHA256_S2, ASI_SHA256_S3});
    assign insn_sha3  = f_xy | f_x1 | f_x2 | f_x4 | f_yx;
    assign insn_undef = valid && !(insn_aes || insn_sha2 || insn_sha3);

    assign aes_dec = f_decs | f_decm;
    assign aes_mix = f_encm | f_decm;

    // ----------------------------------------
    // Datapaths

    assign sha2_rs1 = {XLEN{insn_sha2}} & req.rs1;  // Hold quiet unless SHA2

    sha256_sigma u_sha256 (
        .rs1    (sha2_rs1),
        .ss     (req.uop[1:0]),
        .result (result_sha2)
    );

    sha3_index u_sha3 (
        .rs1    (req.rs1),
        .rs2    (req.rs2),
        .shamt  (req.shamt),
        .f_xy   (f_xy),
        .f_x1   (f_x1),
        .f_x2   (f_x2),
        .f_x4   (f_x4),
        .f_yx   (f_yx),
        .result (result_sha3)
    );

    aes_sub_mix u_aes (
        .g_clk (g_clk),
        .rst   (rst),
        .valid (insn_aes),
        .dec   (aes_dec),
        .mix   (aes_mix),
        .rs1   (req.rs1),
        .ready (aes_ready),
        .rd    (result_aes)
    );

    // ----------------------------------------
    // Ready and result

    assign ready = insn_sha2 || insn_sha3 || insn_undef  // Zero latency
                || (insn_aes && aes_ready);

    assign result = ({XLEN{insn_aes}}  & result_aes)
                  | ({XLEN{insn_sha2}} & result_sha2)
                  | ({XLEN{insn_sha3}} & result_sha3);  // Undefined gives zero

endmodule

//--- logic/aes_sub_mix.sv
`timescale 1ns/10ps
// AES datapath for SubBytes over one shared S-box and single-cycle MixColumns
// SubBytes takes four cycles of valid, MixColumns completes at once
module aes_sub_mix (
    input  logic           g_clk,  // Core clock
    input  logic           rst,    // Sync reset, active high
    input  logic           valid,  // AES op presented
    input  logic           dec,    // Inverse direction
    input  logic           mix,    // MixColumns, else SubBytes
    input  asi_pkg::word_t rs1,    // Input word or column
    output logic           ready,  // Result available this cycle
    output asi_pkg::word_t rd      // Result word
);
    import asi_pkg::*;

    // Multiply by x in GF(2^8)
    function automatic gf_byte_t xtime(input gf_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? AES_POLY : 8'h00);
    endfunction

    sub_phase_e phase;      // Current byte position
    sub_phase_e phase_nxt;
    logic       sub_go;     // SubBytes under way
    logic       sub_done;   // SubBytes handshake
    gf_byte_t   sbox_in;
    gf_byte_t   sbox_out;
    gf_byte_t   sub_b0;     // Finished bytes 0..2
    gf_byte_t   sub_b1;
    gf_byte_t   sub_b2;
    word_t      mix_in;     // Gated column
    gf_byte_t   col [4];
    gf_byte_t   c2  [4];    // col * 2
    gf_byte_t   c4  [4];    // col * 4
    gf_byte_t   c8  [4];    // col * 8
    word_t      mix_res;

    // ----------------------------------------
    // SubBytes sequencer

    assign sub_go   = valid && !mix;
    assign ready    = valid && (mix || phase == SUB_B3);  // Mix never leaves B0
    assign sub_done = sub_go && ready;

    always_comb begin
        case (phase)  // Byte under lookup
            SUB_B0:  sbox_in = rs1[7:0];
            SUB_B1:  sbox_in = rs1[15:8];
            SUB_B2:  sbox_in = rs1[23:16];
            default: sbox_in = rs1[31:24];
        endcase
    end

    aes_sbox u_sbox (
        .in_byte  (sbox_in),
        .inv      (dec),
        .out_byte (sbox_out)
    );

    always_comb begin
        phase_nxt = SUB_B0;  // Idle or done
        if (sub_go && !sub_done) begin
            case (phase)
                SUB_B0:  phase_nxt = SUB_B1;
                SUB_B1:  phase_nxt = SUB_B2;
                default: phase_nxt = SUB_B3;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            phase <= SUB_B0;
        end else begin
            phase <= phase_nxt;
        end
    end

    always_ff @(posedge g_clk) begin
        if (sub_go) begin
            case (phase)
                SUB_B0:  sub_b0 <= sbox_out;
                SUB_B1:  sub_b1 <= sbox_out;
                SUB_B2:  sub_b2 <= sbox_out;
                default: ;  // Byte 3 goes straight out
            endcase
        end
    end

    // ----------------------------------------
    // MixColumns, byte 0 is row 0

    assign mix_in = {XLEN{valid && mix}} & rs1;  // Quiet when unused

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            col[i] = mix_in[8*i +: 8];
            c2[i]  = xtime(col[i]);
            c4[i]  = xtime(c2[i]);
            c8[i]  = xtime(c4[i]);
        end
        for (int i = 0; i < 4; i++) begin
            if (dec) begin  // Rows of {0e, 0b, 0d, 09}
                mix_res[8*i +: 8] = (c8[i] ^ c4[i] ^ c2[i])
                                  ^ (c8[(i+1)%4] ^ c2[(i+1)%4] ^ col[(i+1)%4])
                                  ^ (c8[(i+2)%4] ^ c4[(i+2)%4] ^ col[(i+2)%4])
                                  ^ (c8[(i+3)%4] ^ col[(i+3)%4]);
            end else begin  // Rows of {02, 03, 01, 01}
                mix_res[8*i +: 8] = c2[i] ^ c2[(i+1)%4] ^ col[(i+1)%4]
                                  ^ col[(i+2)%4] ^ col[(i+3)%4];
            end
        end
    end

    assign rd = mix ? mix_res : {sbox_out, sub_b2, sub_b1, sub_b0};

endmodule

//--- logic/aes_sbox.sv
`timescale 1ns/10ps
// AES forward and inverse S-box for one byte
// Shared GF(2^8) inversion wrapped by the affine maps
module aes_sbox (
    input  asi_pkg::gf_byte_t in_byte,  // Byte to substitute
    input  logic              inv,      // Inverse S-box when set
    output asi_pkg::gf_byte_t out_byte
);
    import asi_pkg::*;

    // Multiply in GF(2^8) modulo the AES polynomial
    function automatic gf_byte_t gf_mul(input gf_byte_t a, input gf_byte_t b);
        gf_byte_t acc;
        gf_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? AES_POLY : 8'h00);  // xtime
        end
        return acc;
    endfunction

    // a^254 is the inverse, and maps zero to zero
    function automatic gf_byte_t gf_inv(input gf_byte_t a);
        gf_byte_t sq;
        gf_byte_t acc;
        sq  = gf_mul(a, a);  // a^2
        acc = sq;
        for (int i = 0; i < 6; i++) begin
            sq  = gf_mul(sq, sq);    // a^4 .. a^128
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Rotate left within a byte
    function automatic gf_byte_t rotl(input gf_byte_t a, input int n);
        return gf_byte_t'((a << n) | (a >> (8 - n)));
    endfunction

    function automatic gf_byte_t affine_fwd(input gf_byte_t a);
        return a ^ rotl(a, 1) ^ rotl(a, 2) ^ rotl(a, 3) ^ rotl(a, 4) ^ AES_AFFINE_C;
    endfunction

    function automatic gf_byte_t affine_inv(input gf_byte_t a);
        return rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ AES_AFFINE_INV_C;
    endfunction

    // ----------------------------------------
    // Datapath

    gf_byte_t pre_byte;  // Inversion input
    gf_byte_t inv_byte;  // Inversion output

    // Decrypt undoes the affine map first, encrypt applies it last
    assign pre_byte = inv ? affine_inv(in_byte) : in_byte;
    assign inv_byte = gf_inv(pre_byte);
    assign out_byte = inv ? inv_byte : affine_fwd(inv_byte);

endmodule

//--- logic/sha256_sigma.sv
`timescale 1ns/10ps
// SHA-256 small and big sigma functions, one selected per op
module sha256_sigma (
    input  asi_pkg::word_t rs1,    // Operand, zero when not in use
    input  logic [1:0]     ss,     // Which sigma
    output asi_pkg::word_t result
);
    import asi_pkg::*;

    // Rotate right by a fixed amount
    function automatic word_t ror(input word_t v, input int n);
        return (v >> n) | (v << (XLEN - n));
    endfunction

    word_t s0;  // Message schedule sigma 0
    word_t s1;  // Message schedule sigma 1
    word_t s2;  // Compression Sigma 0
    word_t s3;  // Compression Sigma 1

    assign s0 = ror(rs1, 7) ^ ror(rs1, 18) ^ (rs1 >> 3);
    assign s1 = ror(rs1, 17) ^ ror(rs1, 19) ^ (rs1 >> 10);
    assign s2 = ror(rs1, 2) ^ ror(rs1, 13) ^ ror(rs1, 22);
    assign s3 = ror(rs1, 6) ^ ror(rs1, 11) ^ ror(rs1, 25);

    always_comb begin
        case (ss)
            2'd0:    result = s0;
            2'd1:    result = s1;
            2'd2:    result = s2;
            default: result = s3;
        endcase
    end

endmodule

//--- logic/sha3_index.sv
`timescale 1ns/10ps
// Keccak lane-index helper functions
// Index arithmetic modulo 5 followed by a small left shift
module sha3_index (
    input  asi_pkg::word_t  rs1,    // Source register 1, x coordinate
    input  asi_pkg::word_t  rs2,    // Source register 2, y coordinate
    input  asi_pkg::shamt_t shamt,  // Post-shift amount
    input  logic            f_xy,   // One-hot function strobes
    input  logic            f_x1,
    input  logic            f_x2,
    input  logic            f_x4,
    input  logic            f_yx,
    output asi_pkg::word_t  result  // Shifted lane index
);
    import asi_pkg::*;

    logic [2:0] x;       // rs1 mod 5
    logic [2:0] y;       // rs2 mod 5
    logic [2:0] x_p1;    // (x+1) mod 5
    logic [2:0] x_p2;    // (x+2) mod 5
    logic [2:0] x_p4;    // (x+4) mod 5
    logic [2:0] yx_row;  // (2x+3y) mod 5
    logic [2:0] col;
    logic [2:0] row;
    logic [4:0] base;    // col + 5*row, at most 24
    logic       any_f;

    assign x      = 3'(rs1 % KECCAK_DIM);
    assign y      = 3'(rs2 % KECCAK_DIM);
    assign x_p1   = 3'((int'(x) + 1) % KECCAK_DIM);
    assign x_p2   = 3'((int'(x) + 2) % KECCAK_DIM);
    assign x_p4   = 3'((int'(x) + 4) % KECCAK_DIM);
    assign yx_row = 3'((2 * int'(x) + 3 * int'(y)) % KECCAK_DIM);

    always_comb begin
        col = '0;
        row = y;  // Row is y except for YX
        if (f_xy) col = x;
        else if (f_x1) col = x_p1;
        else if (f_x2) col = x_p2;
        else if (f_x4) col = x_p4;
        else if (f_yx) begin
            col = y;       // y moves into the column slot
            row = yx_row;
        end
    end

    assign base   = 5'(int'(col) + KECCAK_DIM * int'(row));
    assign any_f  = f_xy | f_x1 | f_x2 | f_x4 | f_yx;
    assign result = any_f ? (word_t'(base) << shamt) : '0;  // Zero when idle

endmodule

//--- logic/asi_pkg.sv
// Shared types and op-code constants for the algorithm-specific instruction unit
// Covers AES, SHA-256 and SHA-3 micro-ops of the execute stage
package asi_pkg;

    localparam int XLEN = 32;  // Data path width

    typedef logic [XLEN-1:0] word_t;     // Source operand or result
    typedef logic [4:0]      asi_uop_t;  // {class, function}
    typedef logic [1:0]      asi_cls_t;  // Class field, uop[4:3]
    typedef logic [1:0]      shamt_t;    // SHA3 post-shift amount
    typedef logic [7:0]      gf_byte_t;  // One AES state byte

    // ----------------------------------------
    // Micro-op classes

    localparam asi_cls_t ASI_CLS_AES  = 2'b01;  // AES sub and mix
    localparam asi_cls_t ASI_CLS_SHA2 = 2'b10;  // SHA-256 sigmas
    localparam asi_cls_t ASI_CLS_SHA3 = 2'b11;  // Keccak index helpers

    // ----------------------------------------
    // Full micro-op codes

    localparam asi_uop_t ASI_AES_ENCS  = 5'b01_000;  // Forward SubBytes
    localparam asi_uop_t ASI_AES_DECS  = 5'b01_001;  // Inverse SubBytes
    localparam asi_uop_t ASI_AES_ENCM  = 5'b01_010;  // MixColumns
    localparam asi_uop_t ASI_AES_DECM  = 5'b01_011;  // InvMixColumns

    localparam asi_uop_t ASI_SHA256_S0 = 5'b10_000;  // Small sigma 0
    localparam asi_uop_t ASI_SHA256_S1 = 5'b10_001;  // Small sigma 1
    localparam asi_uop_t ASI_SHA256_S2 = 5'b10_010;  // Big sigma 0
    localparam asi_uop_t ASI_SHA256_S3 = 5'b10_011;  // Big sigma 1

    localparam asi_uop_t ASI_SHA3_XY   = 5'b11_000;  // x + 5y
    localparam asi_uop_t ASI_SHA3_X1   = 5'b11_001;  // x+1 column
    localparam asi_uop_t ASI_SHA3_X2   = 5'b11_010;  // x+2 column
    localparam asi_uop_t ASI_SHA3_X4   = 5'b11_011;  // x+4 column
    localparam asi_uop_t ASI_SHA3_YX   = 5'b11_100;  // Rho-pi lane move

    // ----------------------------------------
    // Datapath constants

    localparam gf_byte_t AES_POLY         = 8'h1b;  // x^8 = x^4+x^3+x+1
    localparam gf_byte_t AES_AFFINE_C     = 8'h63;  // Forward affine offset
    localparam gf_byte_t AES_AFFINE_INV_C = 8'h05;  // Inverse affine offset
    localparam int       KECCAK_DIM       = 5;      // Lanes per row/column

    // One request from the core stage, 71 bits
    typedef struct packed {
        asi_uop_t uop;    // Class and function
        word_t    rs1;    // Source register 1
        word_t    rs2;    // Source register 2
        shamt_t   shamt;  // SHA3 post-shift
    } asi_req_t;

    // SubBytes byte position, one S-box lookup per state
    typedef enum logic [1:0] {
        SUB_B0 = 2'd0,  // Byte 0, also idle
        SUB_B1 = 2'd1,
        SUB_B2 = 2'd2,
        SUB_B3 = 2'd3   // Last byte, result ready
    } sub_phase_e;

endpackage
